// File: logic/memtest_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Shared types for the memory test subsystem
////////////////////////////////////////////////////////////////////////////

package memtest_pkg;

    // Data path widths
    typedef logic [15:0] word_t;          // One memory word
    typedef logic [31:0] count_t;         // Pass or fail tally
    typedef logic [15:0] seconds_t;       // Binary elapsed seconds
    typedef logic [15:0] bcd_minutes_t;   // Four BCD digits of minutes

    // Config register index
    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t cfg_ctrl_addr  = 2'd0;  // Bit 0 is run
    localparam cfg_addr_t cfg_seed_addr  = 2'd1;  // LFSR start value
    localparam cfg_addr_t cfg_fault_addr = 2'd2;  // Stuck-at-one mask

    // Index 3 is unmapped, writes there are dropped

    // Tester FSM
    typedef enum logic [1:0] {
        idle,          // Waiting for run
        write_phase,   // Filling memory with the pattern
        read_phase,    // Reading back, plus one drain cycle
        finish         // Counters updated, pass_done high
    } tester_state_t;

endpackage

`default_nettype wire

// File: logic/mem_bus_if.sv
`default_nettype none
`timescale 1ns/1ps

// Tester to RAM bus, write on we, rdata one cycle after re
interface mem_bus_if import memtest_pkg::*; #(
    parameter int addr_width = 8
) ();

    logic [addr_width-1:0] addr;   // Word address
    word_t                 wdata;  // Write data
    logic                  we;     // Write strobe
    logic                  re;     // Read strobe
    word_t                 rdata;  // Registered read data

    // Pattern tester side
    modport tester (
        output addr, wdata, we, re,
        input  rdata
    );

    // RAM side
    modport memory (
        input  addr, wdata, we, re,
        output rdata
    );

endinterface

`default_nettype wire

// File: logic/test_config.sv
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Config registers written by single-cycle strobes
////////////////////////////////////////////////////////////////////////////

module test_config import memtest_pkg::*; (
    input  logic      clk_gui,
    input  logic      timer_reset,
    input  logic      cfg_write,    // Write strobe, always accepted
    input  cfg_addr_t cfg_addr,     // Register index
    input  word_t     cfg_wdata,    // Write data
    output logic      run,          // Control bit 0
    output word_t     seed,         // Pattern seed
    output word_t     fault_mask    // Stuck-at-one bits
);

    word_t seed_wdata;

    // All-zero seed would freeze the LFSR
    assign seed_wdata = (cfg_wdata == '0) ? word_t'(1) : cfg_wdata;

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            run        <= 1'b0;
            seed       <= '0;
            fault_mask <= '0;   // No faults injected
        end else if (cfg_write) begin
            case (cfg_addr)
                cfg_ctrl_addr: begin
                    run <= cfg_wdata[0];   // Other control bits ignored
                end
                cfg_seed_addr: begin
                    seed <= seed_wdata;
                end
                cfg_fault_addr: begin
                    fault_mask <= cfg_wdata;
                end
                default: begin
                    // Unmapped index, nothing to store
                end
            endcase
        end
    end

    // Outputs come straight from the flops
    // so every write shows one cycle after its strobe

endmodule

`default_nettype wire

// File: logic/pattern_tester.sv
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Write / read / compare sweep over the test RAM
////////////////////////////////////////////////////////////////////////////

module pattern_tester import memtest_pkg::*; #(
    parameter int addr_width = 8
) (
    input  logic      clk_gui,
    input  logic      timer_reset,
    input  logic      run,          // Keep sweeping while high
    input  word_t     seed,         // Sampled at pass start
    mem_bus_if.tester bus,
    output count_t    pass_count,
    output count_t    fail_count,
    output logic      pass_done,    // One cycle per finished pass
    output logic      busy
);

    localparam int depth = 2 ** addr_width;
    localparam logic [addr_width:0] last_word  = (addr_width + 1)'(depth - 1);
    localparam logic [addr_width:0] drain_step = (addr_width + 1)'(depth);

    tester_state_t       state;
    logic [addr_width:0] step_q;       // Extra top bit marks the drain cycle
    word_t               lfsr_q;       // Current pattern word
    word_t               lfsr_next;
    word_t               seed_q;       // Seed of the running pass
    word_t               exp_q;        // Expected word for rdata
    logic                cmp_valid_q;  // rdata holds a read result
    logic                err_q;        // Sticky mismatch of this pass
    logic                mismatch;
    logic                pass_bad;
    logic                start_pass;

    // Fibonacci LFSR, taps 16 14 13 11, shift left
    assign lfsr_next = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};

    assign start_pass = run && ((state == idle) || (state == finish));

    // Bus drive
    assign bus.addr  = step_q[addr_width-1:0];
    assign bus.wdata = lfsr_q;                              // Address k gets k-th LFSR state
    assign bus.we    = (state == write_phase);
    assign bus.re    = (state == read_phase) && !step_q[addr_width];  // Not in drain cycle

    assign mismatch  = cmp_valid_q && (bus.rdata != exp_q);
    assign pass_bad  = err_q || mismatch;                   // Includes the last word
    assign pass_done = (state == finish);
    assign busy      = (state != idle);

    ////////////////////////////////////////////////////////////////////////
    // Pattern generation

    always_ff @(posedge clk_gui) begin
        if (start_pass) begin
            seed_q <= seed;
            lfsr_q <= seed;                 // Address 0 holds the seed
        end else if ((state == write_phase) && (step_q == last_word)) begin
            lfsr_q <= seed_q;               // Rewind for the read sweep
        end else if (bus.we || bus.re) begin
            lfsr_q <= lfsr_next;
        end
    end

    // Delay the expected word to line up with rdata
    always_ff @(posedge clk_gui) begin
        if (bus.re) begin
            exp_q <= lfsr_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Sweep FSM and tallies

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            state       <= idle;
            step_q      <= '0;
            cmp_valid_q <= 1'b0;
            err_q       <= 1'b0;
            pass_count  <= '0;
            fail_count  <= '0;
        end else begin
            cmp_valid_q <= bus.re;   // Read latency of one
            case (state)
                idle, finish: begin
                    step_q <= '0;
                    err_q  <= 1'b0;
                    state  <= start_pass ? write_phase : idle;  // Back to back while run
                end
                write_phase: begin
                    if (step_q == last_word) begin
                        state  <= read_phase;
                        step_q <= '0;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                read_phase: begin
                    if (mismatch) begin
                        err_q <= 1'b1;
                    end
                    if (step_q == drain_step) begin
                        state <= finish;    // Last compare happens here
                        if (pass_bad) begin
                            fail_count <= fail_count + 1'b1;
                        end else begin
                            pass_count <= pass_count + 1'b1;
                        end
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/test_ram.sv
`default_nettype none
`timescale 1ns/1ps

// Stand-in for the SDRAM chip, single port with registered read
module test_ram import memtest_pkg::*; #(
    parameter int addr_width = 8
) (
    input  logic      clk_gui,
    input  word_t     fault_mask,   // Ones model stuck-at-one cells
    mem_bus_if.memory bus
);

    localparam int depth = 2 ** addr_width;

    word_t mem [depth];
    word_t mask_q;                  // Mask in force for this write sweep

    // Frozen while the tester writes, so a mask change lands on the next pass
    always_ff @(posedge clk_gui) begin
        if (!bus.we) begin
            mask_q <= fault_mask;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk_gui) begin
        if (bus.we) begin
            mem[bus.addr] <= bus.wdata | mask_q;   // Faulty bits read back as one
        end
        if (bus.re) begin
            bus.rdata <= mem[bus.addr];           // Valid the next cycle
        end
    end

endmodule

`default_nettype wire

// File: logic/elapsed_timer.sv
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Elapsed run time, binary seconds and BCD minutes
////////////////////////////////////////////////////////////////////////////

module elapsed_timer import memtest_pkg::*; #(
    parameter int clk_gui_hz = 27500000
) (
    input  logic         clk_gui,
    input  logic         timer_reset,
    output seconds_t     secs,
    output bcd_minutes_t mins
);

    localparam logic [31:0] sec_max = 32'(clk_gui_hz - 1);
    localparam logic [31:0] min_max = 32'(clk_gui_hz * 60 - 1);

    logic [31:0] sec_cnt;   // Cycles into the current second
    logic [31:0] min_cnt;   // Cycles into the current minute

    // Add one to a four digit BCD value, 9999 rolls to 0000
    function automatic bcd_minutes_t bcd_inc(input bcd_minutes_t value);
        bcd_minutes_t result;
        logic         carry;
        result = value;
        carry  = 1'b1;
        for (int d = 0; d < 4; d++) begin
            if (carry) begin
                if (result[d*4 +: 4] == 4'd9) begin
                    result[d*4 +: 4] = 4'd0;      // Carry into next digit
                end else begin
                    result[d*4 +: 4] = result[d*4 +: 4] + 4'd1;
                    carry            = 1'b0;
                end
            end
        end
        return result;
    endfunction

    // Seconds
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            sec_cnt <= '0;
            secs    <= '0;
        end else if (sec_cnt == sec_max) begin
            sec_cnt <= '0;
            secs    <= secs + 1'b1;   // Wraps at 65535
        end else begin
            sec_cnt <= sec_cnt + 1'b1;
        end
    end

    // Minutes, kept apart from the seconds counter
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            min_cnt <= '0;
            mins    <= '0;
        end else if (min_cnt == min_max) begin
            min_cnt <= '0;
            mins    <= bcd_inc(mins);
        end else begin
            min_cnt <= min_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/memtest_top.sv
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Memory test subsystem, everything on clk_gui
////////////////////////////////////////////////////////////////////////////

module memtest_top import memtest_pkg::*; #(
    parameter int addr_width = 8,          // RAM depth is 2**addr_width
    parameter int clk_gui_hz = 27500000    // Cycles per second
) (
    input  logic         clk_gui,
    input  logic         timer_reset,
    input  logic         cfg_write,
    input  cfg_addr_t    cfg_addr,
    input  word_t        cfg_wdata,
    output count_t       pass_count,
    output count_t       fail_count,
    output logic         pass_done,
    output logic         busy,
    output seconds_t     secs,
    output bcd_minutes_t mins
);

    logic  run;
    word_t seed;
    word_t fault_mask;

    mem_bus_if #(.addr_width(addr_width)) mem_bus ();

    // Register block
    test_config u_config (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .run         (run),
        .seed        (seed),
        .fault_mask  (fault_mask)
    );

    pattern_tester #(.addr_width(addr_width)) u_tester (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .run         (run),
        .seed        (seed),
        .bus         (mem_bus.tester),
        .pass_count  (pass_count),
        .fail_count  (fail_count),
        .pass_done   (pass_done),
        .busy        (busy)
    );

    // Memory under test
    test_ram #(.addr_width(addr_width)) u_ram (
        .clk_gui     (clk_gui),
        .fault_mask  (fault_mask),
        .bus         (mem_bus.memory)
    );

    elapsed_timer #(.clk_gui_hz(clk_gui_hz)) u_timer (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .secs        (secs),
        .mins        (mins)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

// 10 ns clock and reset held high for the first 8 cycles
module tb_clock (
    output logic clk_gui,
    output logic timer_reset
);

    initial begin
        clk_gui = 1'b0;
        forever #5 clk_gui = ~clk_gui;
    end

    initial begin
        timer_reset = 1'b1;
        repeat (8) @(posedge clk_gui);
        #1 timer_reset = 1'b0;   // Released just after the 8th edge
    end

endmodule

`default_nettype wire

// File: testbench/memtest_checker.sv
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Watches the DUT outputs and compares them with expected values
////////////////////////////////////////////////////////////////////////////

module memtest_checker import memtest_pkg::*; (
    input  logic         clk_gui,
    input  logic         timer_reset,
    input  count_t       pass_count,
    input  count_t       fail_count,
    input  logic         pass_done,
    input  logic         busy,
    input  seconds_t     secs,
    input  bcd_minutes_t mins,
    output int           errors
);

    count_t pulses;        // pass_done pulses seen since reset
    int     checks;

    initial begin
        errors = 0;
        checks = 0;
    end

    // Old value of pass_done is read here, so each one-cycle pulse counts once
    always @(posedge clk_gui) begin
        if (timer_reset) begin
            pulses <= '0;
        end else if (pass_done) begin
            pulses <= pulses + 1'b1;
        end
    end

    task automatic expect_counts(input count_t pass_exp, input count_t fail_exp,
                                 input logic busy_exp);
        checks = checks + 1;
        if (pass_count !== pass_exp) begin
            $display("CHECK FAILED @ %0t: pass_count %0d, expected %0d",
                     $time, pass_count, pass_exp);
            errors = errors + 1;
        end
        if (fail_count !== fail_exp) begin
            $display("CHECK FAILED @ %0t: fail_count %0d, expected %0d",
                     $time, fail_count, fail_exp);
            errors = errors + 1;
        end
        if (busy !== busy_exp) begin
            $display("CHECK FAILED @ %0t: busy %b, expected %b", $time, busy, busy_exp);
            errors = errors + 1;
        end
        // Every finished pass bumps exactly one counter
        if (pass_count + fail_count !== pulses) begin
            $display("CHECK FAILED @ %0t: counters total %0d, pass_done pulses %0d",
                     $time, pass_count + fail_count, pulses);
            errors = errors + 1;
        end
    endtask

    task automatic expect_time(input seconds_t secs_exp, input bcd_minutes_t mins_exp);
        checks = checks + 1;
        if (secs !== secs_exp) begin
            $display("CHECK FAILED @ %0t: secs %0d, expected %0d", $time, secs, secs_exp);
            errors = errors + 1;
        end
        if (mins !== mins_exp) begin
            $display("CHECK FAILED @ %0t: mins %h, expected %h", $time, mins, mins_exp);
            errors = errors + 1;
        end
    endtask

    // Timeouts and file trouble
    task automatic note_failure(input string msg);
        $display("ERROR @ %0t: %s", $time, msg);
        errors = errors + 1;
    endtask

    task automatic print_summary();
        $display("Checks run: %0d, errors: %0d", checks, errors);
    endtask

endmodule

`default_nettype wire

// File: testbench/tb_memtest.sv
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Top testbench that replays the trace file against the memory tester
////////////////////////////////////////////////////////////////////////////

module tb_memtest import memtest_pkg::*; ();

    logic         clk_gui;
    logic         timer_reset;
    logic         cfg_write;
    cfg_addr_t    cfg_addr;
    word_t        cfg_wdata;
    count_t       pass_count;
    count_t       fail_count;
    logic         pass_done;
    logic         busy;
    seconds_t     secs;
    bcd_minutes_t mins;
    int           errors;
    int           cycle;     // Edges since reset release
    logic         abort;

    tb_clock clock_gen (.clk_gui(clk_gui), .timer_reset(timer_reset));

    memtest_top #(.addr_width(4), .clk_gui_hz(10)) UUT (
        .clk_gui(clk_gui), .timer_reset(timer_reset), .cfg_write(cfg_write),
        .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .pass_count(pass_count),
        .fail_count(fail_count), .pass_done(pass_done), .busy(busy),
        .secs(secs), .mins(mins)
    );

    memtest_checker u_checker (
        .clk_gui(clk_gui), .timer_reset(timer_reset), .pass_count(pass_count),
        .fail_count(fail_count), .pass_done(pass_done), .busy(busy),
        .secs(secs), .mins(mins), .errors(errors)
    );

    always @(posedge clk_gui) begin
        if (timer_reset) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    task automatic next_cycle();
        @(posedge clk_gui);
        #1;                              // Drive and sample off the edge
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) next_cycle();
    endtask

    task automatic write_reg(input cfg_addr_t addr, input word_t data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_write = 1'b0;
    endtask

    task automatic wait_pulses(input int n);
        int t;
        for (int i = 0; i < n && !abort; i++) begin
            t = 0;
            do begin
                next_cycle();
                t++;
            end while (!pass_done && t < 200);
            if (!pass_done) begin
                u_checker.note_failure("no pass_done within 200 cycles");
                abort = 1'b1;
            end
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (busy && t < 100) begin
            next_cycle();
            t++;
        end
        if (busy) begin
            u_checker.note_failure("tester still busy 100 cycles after run was cleared");
            abort = 1'b1;
        end
    endtask

    task automatic wait_cycle(input int n);
        int t;
        t = 0;
        if (cycle > n) begin
            u_checker.note_failure($sformatf("cycle %0d already passed, now at %0d", n, cycle));
            abort = 1'b1;
        end
        while (cycle < n && t < 10000) begin
            next_cycle();
            t++;
        end
        if (cycle != n && !abort) begin
            u_checker.note_failure($sformatf("cycle %0d not reached in time", n));
            abort = 1'b1;
        end
    endtask

    initial begin
        int          fd;
        int          t;
        string       line;
        logic [7:0]  op;
        logic [31:0] a, b, c;
        cfg_write = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        abort     = 1'b0;
        void'($urandom(32'he3));
        t = 0;
        while (timer_reset && t < 50) begin
            next_cycle();
            t++;
        end
        if (timer_reset) begin
            u_checker.note_failure("timer_reset still high after 50 cycles");
            abort = 1'b1;
        end
        fd = $fopen("testbench/memtest_trace.txt", "r");
        if (fd == 0) begin
            u_checker.note_failure("cannot open testbench/memtest_trace.txt");
            abort = 1'b1;
        end
        while (!abort && fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == 8'h23) begin
                continue;                  // Blank or comment
            end
            a = '0;
            b = '0;
            c = '0;
            void'($sscanf(line, "%c %h %h %h", op, a, b, c));
            idle_gap();
            case (op)
                "W": write_reg(cfg_addr_t'(a), word_t'(b));
                "P": wait_pulses(a);
                "B": wait_idle();
                "C": u_checker.expect_counts(a, b, c[0]);
                "T": begin
                    wait_cycle(a);
                    if (!abort) begin
                        u_checker.expect_time(seconds_t'(b), bcd_minutes_t'(c));
                    end
                end
                default: u_checker.note_failure($sformatf("unknown trace command %s", line));
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        u_checker.print_summary();
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/memtest_trace.txt
# W reg data | P pulses | B wait for not busy | C pass fail busy | T cycle secs mins
# All numbers hex, cycles counted from reset release, mins in BCD
T 1E 3 0
C 0 0 0
W 1 ACE1
W 0 1
P 3
W 0 0
B
C 4 0 0
W 0 1
P 2
W 0 0
B
C 7 0 0
W 1 FFFF
W 2 8000
W 0 1
P 2
W 0 0
B
C A 0 0
T 258 3C 0001
W 2 0001
W 0 1
P 2
W 0 0
B
C A 3 0
W 2 0000
W 0 1
P 1
W 2 0001
W 0 0
B
C C 3 0
W 0 1
P 1
W 0 0
B
C C 5 0
W 2 8000
W 0 1
P 1
W 1 0000
W 0 0
B
C E 5 0
W 0 1
P 1
W 0 0
B
C E 7 0
T 1770 258 0010

// File: memtest_top.f
logic/memtest_pkg.sv
logic/mem_bus_if.sv
logic/test_config.sv
logic/pattern_tester.sv
logic/test_ram.sv
logic/elapsed_timer.sv
logic/memtest_top.sv
testbench/tb_clock.sv
testbench/memtest_checker.sv
testbench/tb_memtest.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory tester simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f memtest_top.f --top-module tb_memtest \
    --Mdir obj_dir -o sim_memtest > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_memtest > sim.log 2>&1
cat sim.log

grep -q "^=== PASS ===$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
